// File: logic/busPkg.sv
`default_nettype none

package busPkg;

   // data word carried on each beat
   localparam int DATA_W = 32;

   // external byte address
   localparam int BUS_ADDR_W = 32;

   // burst length field, counts beats
   localparam int BUS_LEN_W = 8;

endpackage

`default_nettype wire

// File: logic/addrGenPkg.sv
`default_nettype none

package addrGenPkg;

   // stage buffer address, msb picks the bank
   localparam int MEM_ADDR_W = 10;

   // period and duty counters
   localparam int PERIOD_W = 10;

endpackage

`default_nettype wire

// File: logic/addrGen.sv
`timescale 1ns/1ps
`default_nettype none

module addrGen #(
   parameter int MEM_ADDR_W = addrGenPkg::MEM_ADDR_W,
   parameter int PERIOD_W = addrGenPkg::PERIOD_W
)
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run,
   input  wire  [MEM_ADDR_W-1:0] iterations,
   input  wire  [PERIOD_W-1:0]   period,
   input  wire  [PERIOD_W-1:0]   duty,
   input  wire  [MEM_ADDR_W-1:0] start,
   input  wire  [MEM_ADDR_W-1:0] shift,
   input  wire  [MEM_ADDR_W-1:0] incr,
   input  wire                   ready,
   output logic                  valid,
   output logic [MEM_ADDR_W-1:0] addr,
   output logic                  done
);

   logic                  active;
   logic [MEM_ADDR_W-1:0] iterCnt;
   logic [PERIOD_W-1:0]   slotCnt;
   logic [MEM_ADDR_W-1:0] rowBase;
   logic                  advance;
   logic                  lastSlot;
   logic                  lastIter;

   assign valid = active && (slotCnt < duty);
   // idle slots move on by themselves
   assign advance = active && (ready || !valid);
   assign lastSlot = slotCnt == period - 1'b1;
   assign lastIter = iterCnt == iterations - 1'b1;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         active <= 1'b0;
         iterCnt <= '0;
         slotCnt <= '0;
         done <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (run)
         begin
            active <= 1'b1;
            iterCnt <= '0;
            slotCnt <= '0;
         end
         else if (advance)
         begin
            if (lastSlot)
            begin
               slotCnt <= '0;
               if (lastIter)
               begin
                  active <= 1'b0;
                  done <= 1'b1;
               end
               else
               begin
                  iterCnt <= iterCnt + 1'b1;
               end
            end
            else
            begin
               slotCnt <= slotCnt + 1'b1;
            end
         end
      end
   end

   // next row starts from the row base, not the running address
   always_ff @(posedge clk)
   begin
      if (run)
      begin
         rowBase <= start;
         addr <= start;
      end
      else if (advance)
      begin
         if (lastSlot)
         begin
            rowBase <= rowBase + shift;
            addr <= rowBase + shift;
         end
         else if (valid)
         begin
            addr <= addr + incr;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/fillEngine.sv
`timescale 1ns/1ps
`default_nettype none

module fillEngine #(
   parameter int DATA_W = busPkg::DATA_W,
   parameter int MEM_ADDR_W = addrGenPkg::MEM_ADDR_W
)
(
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          run,
   input  wire                          pingState,
   input  wire  [busPkg::BUS_ADDR_W-1:0] extAddr,
   input  wire  [busPkg::BUS_LEN_W-1:0]  length,
   input  wire  [MEM_ADDR_W-1:0]         iterA,
   input  wire  [addrGenPkg::PERIOD_W-1:0] perA,
   input  wire  [addrGenPkg::PERIOD_W-1:0] dutyA,
   input  wire  [MEM_ADDR_W-1:0]         shiftA,
   input  wire  [MEM_ADDR_W-1:0]         incrA,
   input  wire                          busReady,
   input  wire  [DATA_W-1:0]             busRdata,
   input  wire                          busLast,
   output logic                         busValid,
   output logic [busPkg::BUS_ADDR_W-1:0] busAddr,
   output logic [busPkg::BUS_LEN_W-1:0]  busLen,
   output logic                         wrEn,
   output logic [MEM_ADDR_W-1:0]         wrAddr,
   output logic [DATA_W-1:0]             wrData,
   output logic                         fillDone
);

   import addrGenPkg::*;

   logic                  busActive;
   logic [MEM_ADDR_W-1:0] fillStart;
   logic                  genValid;
   logic                  genReady;
   logic [MEM_ADDR_W-1:0] genAddr;
   logic                  beat;

   // bottom of the bank the drain is not reading
   always_comb
   begin
      fillStart = '0;
      fillStart[MEM_ADDR_W-1] = ~pingState;
   end

   assign busValid = busActive & genValid;
   assign beat = busValid & busReady;
   assign genReady = busActive & busReady;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busActive <= 1'b0;
      end
      else if (run)
      begin
         busActive <= 1'b1;
      end
      else if (beat && busLast)
      begin
         busActive <= 1'b0;
      end
   end

   // request fields held for the whole burst
   always_ff @(posedge clk)
   begin
      if (run)
      begin
         busAddr <= extAddr;
         busLen <= length;
      end
   end

   addrGen #(
      .MEM_ADDR_W(MEM_ADDR_W),
      .PERIOD_W  (PERIOD_W)
   ) fillGen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .iterations(iterA),
      .period    (perA),
      .duty      (dutyA),
      .start     (fillStart),
      .shift     (shiftA),
      .incr      (incrA),
      .ready     (genReady),
      .valid     (genValid),
      .addr      (genAddr),
      .done      ()
   );

   assign wrEn = beat;
   assign wrAddr = genAddr;
   assign wrData = busRdata;
   assign fillDone = beat & busLast;

endmodule

`default_nettype wire

// File: logic/drainEngine.sv
`timescale 1ns/1ps
`default_nettype none

module drainEngine #(
   parameter int DATA_W = busPkg::DATA_W,
   parameter int MEM_ADDR_W = addrGenPkg::MEM_ADDR_W
)
(
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            run,
   input  wire                            pingState,
   input  wire                            pingPong,
   input  wire  [MEM_ADDR_W-1:0]           iterB,
   input  wire  [addrGenPkg::PERIOD_W-1:0] perB,
   input  wire  [addrGenPkg::PERIOD_W-1:0] dutyB,
   input  wire  [MEM_ADDR_W-1:0]           startB,
   input  wire  [MEM_ADDR_W-1:0]           shiftB,
   input  wire  [MEM_ADDR_W-1:0]           incrB,
   input  wire  [MEM_ADDR_W-1:0]           iter2B,
   input  wire  [MEM_ADDR_W-1:0]           shift2B,
   input  wire  [MEM_ADDR_W-1:0]           incr2B,
   input  wire                            reverseB,
   input  wire  [DATA_W-1:0]               rdData,
   input  wire                            outReady,
   output logic                           rdEn,
   output logic [MEM_ADDR_W-1:0]           rdAddr,
   output logic                           outValid,
   output logic [DATA_W-1:0]               outData,
   output logic                           drainDone
);

   import addrGenPkg::*;

   // outer loop has one slot per pass
   localparam logic [PERIOD_W-1:0] ONE_SLOT = 1;

   logic [MEM_ADDR_W-1:0] outerStart;
   logic                  passValid;
   logic                  passReady;
   logic [MEM_ADDR_W-1:0] passStart;
   logic                  outerDone;
   logic                  outerFin;
   logic                  passActive;
   logic                  innerRun;
   logic                  innerValid;
   logic                  innerReady;
   logic [MEM_ADDR_W-1:0] innerAddr;
   logic                  innerDone;
   logic                  lastIssued;
   logic                  finishing;

   function automatic logic [MEM_ADDR_W-1:0] reverseBits(input logic [MEM_ADDR_W-1:0] word);
      logic [MEM_ADDR_W-1:0] result;
      for (int i = 0; i < MEM_ADDR_W; i++)
      begin
         result[i] = word[MEM_ADDR_W-1-i];
      end
      return result;
   endfunction

   // read the bank filled on the previous run
   always_comb
   begin
      outerStart = startB;
      if (pingPong)
      begin
         outerStart[MEM_ADDR_W-1] = pingState;
      end
   end

   addrGen #(
      .MEM_ADDR_W(MEM_ADDR_W),
      .PERIOD_W  (PERIOD_W)
   ) outerGen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .iterations(iter2B),
      .period    (ONE_SLOT),
      .duty      (ONE_SLOT),
      .start     (outerStart),
      .shift     (shift2B),
      .incr      (incr2B),
      .ready     (passReady),
      .valid     (passValid),
      .addr      (passStart),
      .done      (outerDone)
   );

   // next pass may start in the cycle the current one ends
   assign passReady = ~passActive | innerDone;
   assign innerRun = passValid & passReady;

   addrGen #(
      .MEM_ADDR_W(MEM_ADDR_W),
      .PERIOD_W  (PERIOD_W)
   ) innerGen (
      .clk       (clk),
      .rst       (rst),
      .run       (innerRun),
      .iterations(iterB),
      .period    (perB),
      .duty      (dutyB),
      .start     (passStart),
      .shift     (shiftB),
      .incr      (incrB),
      .ready     (innerReady),
      .valid     (innerValid),
      .addr      (innerAddr),
      .done      (innerDone)
   );

   // only read when the output slot frees up this cycle
   assign innerReady = ~outValid | outReady;
   assign rdEn = innerValid & innerReady;
   assign rdAddr = reverseB ? reverseBits(innerAddr) : innerAddr;

   // buffer read register doubles as the output register
   assign outData = rdData;

   assign lastIssued = innerDone & outerFin;
   assign drainDone = (finishing | lastIssued) & outValid & outReady;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         outValid <= 1'b0;
         passActive <= 1'b0;
         outerFin <= 1'b0;
         finishing <= 1'b0;
      end
      else
      begin
         if (rdEn)
         begin
            outValid <= 1'b1;
         end
         else if (outReady)
         begin
            outValid <= 1'b0;
         end
         if (run)
         begin
            passActive <= 1'b0;
            outerFin <= 1'b0;
            finishing <= 1'b0;
         end
         else
         begin
            if (innerRun)
            begin
               passActive <= 1'b1;
            end
            else if (innerDone)
            begin
               passActive <= 1'b0;
            end
            if (outerDone)
            begin
               outerFin <= 1'b1;
            end
            // last word still waiting at the output
            if (drainDone)
            begin
               finishing <= 1'b0;
            end
            else if (lastIssued)
            begin
               finishing <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/stageBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module stageBuffer #(
   parameter int DATA_W = busPkg::DATA_W,
   parameter int MEM_ADDR_W = addrGenPkg::MEM_ADDR_W
)
(
   input  wire                   clk,
   input  wire                   wrEn,
   input  wire  [MEM_ADDR_W-1:0] wrAddr,
   input  wire  [DATA_W-1:0]     wrData,
   input  wire                   rdEn,
   input  wire  [MEM_ADDR_W-1:0] rdAddr,
   output logic [DATA_W-1:0]     rdData
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[wrAddr] <= wrData;
      end
   end

   // held until the next read
   always_ff @(posedge clk)
   begin
      if (rdEn)
      begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

`default_nettype wire

// File: logic/runControl.sv
`timescale 1ns/1ps
`default_nettype none

module runControl
(
   input  wire  clk,
   input  wire  rst,
   input  wire  run,
   input  wire  pingPong,
   input  wire  fillDone,
   input  wire  drainDone,
   output logic pingState,
   output logic done
);

   logic fillFin;
   logic drainFin;

   assign done = fillFin & drainFin;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pingState <= 1'b0;
         fillFin <= 1'b1;
         drainFin <= 1'b1;
      end
      else if (run)
      begin
         // swap banks each run in ping-pong mode
         pingState <= pingPong ? ~pingState : 1'b0;
         fillFin <= 1'b0;
         drainFin <= 1'b0;
      end
      else
      begin
         if (fillDone)
         begin
            fillFin <= 1'b1;
         end
         if (drainDone)
         begin
            drainFin <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/streamReader.sv
`timescale 1ns/1ps
`default_nettype none

module streamReader #(
   parameter int DATA_W = busPkg::DATA_W,
   parameter int MEM_ADDR_W = addrGenPkg::MEM_ADDR_W
)
(
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            run,
   output logic                           done,
   output logic                           busValid,
   output logic [busPkg::BUS_ADDR_W-1:0]   busAddr,
   output logic [busPkg::BUS_LEN_W-1:0]    busLen,
   input  wire                            busReady,
   input  wire  [DATA_W-1:0]               busRdata,
   input  wire                            busLast,
   output logic                           outValid,
   output logic [DATA_W-1:0]               outData,
   input  wire                            outReady,
   input  wire  [busPkg::BUS_ADDR_W-1:0]   extAddr,
   input  wire  [busPkg::BUS_LEN_W-1:0]    length,
   input  wire  [MEM_ADDR_W-1:0]           iterA,
   input  wire  [addrGenPkg::PERIOD_W-1:0] perA,
   input  wire  [addrGenPkg::PERIOD_W-1:0] dutyA,
   input  wire  [MEM_ADDR_W-1:0]           shiftA,
   input  wire  [MEM_ADDR_W-1:0]           incrA,
   input  wire  [MEM_ADDR_W-1:0]           iterB,
   input  wire  [addrGenPkg::PERIOD_W-1:0] perB,
   input  wire  [addrGenPkg::PERIOD_W-1:0] dutyB,
   input  wire  [MEM_ADDR_W-1:0]           startB,
   input  wire  [MEM_ADDR_W-1:0]           shiftB,
   input  wire  [MEM_ADDR_W-1:0]           incrB,
   input  wire  [MEM_ADDR_W-1:0]           iter2B,
   input  wire  [MEM_ADDR_W-1:0]           shift2B,
   input  wire  [MEM_ADDR_W-1:0]           incr2B,
   input  wire                            reverseB,
   input  wire                            pingPong
);

   logic                  pingState;
   logic                  fillDone;
   logic                  drainDone;
   logic                  wrEn;
   logic [MEM_ADDR_W-1:0] wrAddr;
   logic [DATA_W-1:0]     wrData;
   logic                  rdEn;
   logic [MEM_ADDR_W-1:0] rdAddr;
   logic [DATA_W-1:0]     rdData;

   fillEngine #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W)) fill (.*);

   drainEngine #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W)) drain (.*);

   stageBuffer #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W)) buffer (.*);

   runControl control (.*);

endmodule

`default_nettype wire

// File: sim/tbStreamReader.sv
`timescale 1ns/1ps
`default_nettype none

module tbStreamReader;

   import busPkg::*;
   import addrGenPkg::*;

   localparam int NUM_RUNS = 12;
   localparam int MEM_DEPTH = 2 ** MEM_ADDR_W;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  done;
   logic                  busValid;
   logic [BUS_ADDR_W-1:0] busAddr;
   logic [BUS_LEN_W-1:0]  busLen;
   logic                  busReady;
   logic [DATA_W-1:0]     busRdata;
   logic                  busLast;
   logic                  outValid;
   logic [DATA_W-1:0]     outData;
   logic                  outReady;
   logic [BUS_ADDR_W-1:0] extAddr;
   logic [BUS_LEN_W-1:0]  length;
   logic [MEM_ADDR_W-1:0] iterA;
   logic [PERIOD_W-1:0]   perA;
   logic [PERIOD_W-1:0]   dutyA;
   logic [MEM_ADDR_W-1:0] shiftA;
   logic [MEM_ADDR_W-1:0] incrA;
   logic [MEM_ADDR_W-1:0] iterB;
   logic [PERIOD_W-1:0]   perB;
   logic [PERIOD_W-1:0]   dutyB;
   logic [MEM_ADDR_W-1:0] startB;
   logic [MEM_ADDR_W-1:0] shiftB;
   logic [MEM_ADDR_W-1:0] incrB;
   logic [MEM_ADDR_W-1:0] iter2B;
   logic [MEM_ADDR_W-1:0] shift2B;
   logic [MEM_ADDR_W-1:0] incr2B;
   logic                  reverseB;
   logic                  pingPong;

   logic [31:0]           seed;
   logic [DATA_W-1:0]     modelMem [MEM_DEPTH];
   bit                    known [MEM_DEPTH];
   logic [DATA_W-1:0]     fillData [$];
   logic [DATA_W-1:0]     expData [$];
   bit                    expKnown [$];
   int                    expCount;
   int                    beatCount;
   int                    wordCount;
   int                    curLen;
   logic [BUS_ADDR_W-1:0] curExt;
   logic                  running;
   logic                  modelPing;
   logic                  prevStall;
   logic [DATA_W-1:0]     prevData;
   int                    mismatches;
   int                    failures;

   streamReader i_streamReader (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] randWord();
      seed = xorshift(seed);
      return seed;
   endfunction

   function automatic int pick(input int lo, input int hi);
      logic [31:0] w;
      w = randWord();
      return lo + int'(w % (hi - lo + 1));
   endfunction

   // msb of the result is bit 0 of the address
   function automatic logic [MEM_ADDR_W-1:0] mirrorAddr(input logic [MEM_ADDR_W-1:0] a);
      logic [MEM_ADDR_W-1:0] m;
      logic [MEM_ADDR_W-1:0] rest;
      m = '0;
      rest = a;
      for (int b = 0; b < MEM_ADDR_W; b++)
      begin
         m = {m[MEM_ADDR_W-2:0], rest[0]};
         rest = rest >> 1;
      end
      return m;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      mismatches++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
   endtask

   task automatic reportFailure(input string what);
      failures++;
      $display("Error: %s at %0t", what, $time);
   endtask

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   initial
   begin
      repeat (NUM_RUNS * 4000) @(posedge clk);
      $display("Timeout: the runs did not finish in time");
      $display("Closing counts: %0d mismatches, %0d other errors", mismatches, failures + 1);
      $display("Test failed");
      $finish;
   end

   // bus responder and output sink
   always @(posedge clk)
   begin
      #1;
      busReady = pick(0, 3) != 0;
      outReady = pick(0, 9) < 6;
      if (beatCount < curLen)
         busRdata = fillData[beatCount];
      busLast = beatCount == curLen - 1;
   end

   always @(negedge clk)
   begin
      if (running)
      begin
         if (done && (beatCount < curLen || wordCount < expCount))
            reportFailure("done rose before the last beat and the last word");
         if (busValid)
         begin
            if (busAddr !== curExt)
               reportMismatch("busAddr", busAddr, curExt);
            if (busLen !== BUS_LEN_W'(curLen))
               reportMismatch("busLen", 32'(busLen), 32'(curLen));
            if (beatCount >= curLen)
               reportFailure("busValid high after the burst was complete");
         end
         if (busValid && busReady)
            beatCount++;
         // stalled word must stay put
         if (prevStall)
         begin
            if (!outValid)
               reportFailure("outValid dropped while the output was stalled");
            else if (outData !== prevData)
               reportMismatch("outData", outData, prevData);
         end
         if (outValid && outReady)
         begin
            if (wordCount >= expCount)
               reportFailure("output word beyond the expected count");
            else if (expKnown[wordCount] && outData !== expData[wordCount])
               reportMismatch("outData", outData, expData[wordCount]);
            wordCount++;
         end
         prevStall = outValid && !outReady;
         prevData = outData;
      end
   end

   task automatic doRun(input int r);
      int                    d;
      int                    n;
      int                    gap;
      int                    scale;
      int                    itB;
      int                    duB;
      int                    it2;
      int                    shB;
      int                    inB;
      int                    sh2;
      logic [MEM_ADDR_W-1:0] fillBase;
      logic [MEM_ADDR_W-1:0] drainBase;
      logic [MEM_ADDR_W-1:0] cfgStart;
      logic [MEM_ADDR_W-1:0] startIn;
      logic [MEM_ADDR_W-1:0] a;
      logic [31:0]           cfgIncr2;
      logic                  cfgRev;
      // fill writes rows of d words into one contiguous block
      d = pick(4, 15);
      n = pick(8, 16);
      gap = pick(0, 2);
      curLen = d * n;
      curExt = randWord();
      cfgRev = (r % 3 == 2);
      // reversed reads keep bits 4..1 clear so they land in the filled block
      scale = cfgRev ? 32 : 1;
      itB = pick(1, 3);
      duB = pick(1, 4);
      it2 = 1 + (r % 3);
      shB = pick(0, 2) * scale;
      inB = pick(0, 1) * scale;
      sh2 = pick(0, 1) * scale;
      cfgIncr2 = randWord();
      drainBase = '0;
      drainBase[MEM_ADDR_W-1] = modelPing;
      if (cfgRev)
         drainBase[0] = modelPing;
      cfgStart = drainBase + MEM_ADDR_W'(pick(0, 3) * scale);
      startIn = cfgStart;
      startIn[MEM_ADDR_W-1] = pick(0, 1) == 1;
      expData = {};
      expKnown = {};
      for (int k = 0; k < it2; k++)
         for (int i = 0; i < itB; i++)
            for (int j = 0; j < duB; j++)
            begin
               a = cfgStart + MEM_ADDR_W'(k * sh2 + i * shB + j * inB);
               if (cfgRev)
                  a = mirrorAddr(a);
               expData.push_back(modelMem[a]);
               expKnown.push_back(known[a]);
            end
      expCount = it2 * itB * duB;
      fillBase = '0;
      fillBase[MEM_ADDR_W-1] = ~modelPing;
      fillData = {};
      for (int m = 0; m < curLen; m++)
      begin
         fillData.push_back(randWord());
         a = fillBase + MEM_ADDR_W'((m / d) * d + (m % d));
         modelMem[a] = fillData[m];
         known[a] = 1'b1;
      end
      beatCount = 0;
      wordCount = 0;
      prevStall = 1'b0;
      @(posedge clk);
      #1;
      extAddr = curExt;
      length = BUS_LEN_W'(curLen);
      iterA = MEM_ADDR_W'(n);
      perA = PERIOD_W'(d + gap);
      dutyA = PERIOD_W'(d);
      shiftA = MEM_ADDR_W'(d);
      incrA = MEM_ADDR_W'(1);
      iterB = MEM_ADDR_W'(itB);
      perB = PERIOD_W'(duB);
      dutyB = PERIOD_W'(duB);
      startB = startIn;
      shiftB = MEM_ADDR_W'(shB);
      incrB = MEM_ADDR_W'(inB);
      iter2B = MEM_ADDR_W'(it2);
      shift2B = MEM_ADDR_W'(sh2);
      incr2B = cfgIncr2[MEM_ADDR_W-1:0];
      reverseB = cfgRev;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      running = 1'b1;
      modelPing = ~modelPing;
      @(negedge clk);
      if (done !== 1'b0)
         reportFailure("done still high on the cycle after run");
      if (busValid !== 1'b1)
         reportFailure("busValid did not rise one cycle after run");
      while (done !== 1'b1)
         @(negedge clk);
      running = 1'b0;
      if (beatCount != curLen)
         reportFailure($sformatf("run %0d accepted %0d beats, not %0d", r, beatCount, curLen));
      if (wordCount != expCount)
         reportFailure($sformatf("run %0d gave %0d words, not %0d", r, wordCount, expCount));
   endtask

   initial
   begin
      seed = 32'h320f;
      mismatches = 0;
      failures = 0;
      running = 1'b0;
      modelPing = 1'b0;
      prevStall = 1'b0;
      prevData = '0;
      curLen = 0;
      curExt = '0;
      beatCount = 0;
      wordCount = 0;
      expCount = 0;
      known = '{default: 1'b0};
      rst = 1'b1;
      run = 1'b0;
      busReady = 1'b0;
      busRdata = '0;
      busLast = 1'b0;
      outReady = 1'b0;
      extAddr = '0;
      length = '0;
      iterA = '0;
      perA = '0;
      dutyA = '0;
      shiftA = '0;
      incrA = '0;
      iterB = '0;
      perB = '0;
      dutyB = '0;
      startB = '0;
      shiftB = '0;
      incrB = '0;
      iter2B = '0;
      shift2B = '0;
      incr2B = '0;
      reverseB = 1'b0;
      pingPong = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      if (done !== 1'b1)
         reportFailure("done not high after reset");
      if (busValid !== 1'b0 || outValid !== 1'b0)
         reportFailure("busValid or outValid high after reset");
      // the first run drains a bank nobody filled, so its words go unchecked
      for (int r = 0; r < NUM_RUNS; r++)
         doRun(r);
      $display("Closing counts: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
logic/busPkg.sv
logic/addrGenPkg.sv
logic/addrGen.sv
logic/fillEngine.sv
logic/drainEngine.sv
logic/stageBuffer.sv
logic/runControl.sv
logic/streamReader.sv
sim/tbStreamReader.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbStreamReader \
   -f src.f -o simStreamReader

./obj_dir/simStreamReader | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
